// File: project.f
+incdir+design
design/uart_pkg.sv
design/uart_fifo.sv
design/uart_tx_serializer.sv
design/uart_rx_deserializer.sv
design/uart_top.sv
test/uart_checker.sv
test/tb_uart_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_uart_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_FLAGS ?= -Wno-fatal
PASS_MSG  ?= Simulation completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) $(SIM_FLAGS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: test/tb_uart_top.sv
// Drives rx_i from tx_o or directly; table divisors must be at least 4, and at least 7 for a glitch.
`timescale 1ns/1ps

`include "uart_params.svh"

module tb_uart_top;

    import uart_pkg::*;

    localparam int DEPTH = `UART_FIFO_DEPTH;
    localparam int NUM   = 11;

    typedef enum logic [2:0] {
        mode_loop,
        mode_inject,
        mode_glitch,
        mode_fill,
        mode_flood
    } mode_t;

    typedef struct packed {
        logic [`UART_DIV_W-1:0] div;
        mode_t                  mode;
        uart_byte_t             data;
        logic                   stop;
    } entry_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    entry_t stim [NUM] = '{
        '{16'd15, mode_loop,   8'hA5, 1'b1},
        '{16'd15, mode_loop,   8'h3C, 1'b1},
        '{16'd7,  mode_loop,   8'h01, 1'b1},
        '{16'd4,  mode_loop,   8'hFE, 1'b1},
        '{16'd31, mode_loop,   8'h80, 1'b1},
        '{16'd15, mode_inject, 8'h5A, 1'b0}, // stop bit low, so frame_err is expected.
        '{16'd15, mode_inject, 8'hC3, 1'b1},
        '{16'd31, mode_glitch, 8'h00, 1'b1},
        '{16'd7,  mode_fill,   8'h00, 1'b1},
        '{16'd7,  mode_flood,  8'h00, 1'b1},
        '{16'd9,  mode_inject, 8'h96, 1'b0}
    };

    logic                   clk;
    logic                   rst;
    logic [`UART_DIV_W-1:0] baud_div;
    logic                   stall;
    logic                   wr_en;
    uart_byte_t             wr_data;
    logic                   rd_en;
    logic                   loop_sel;
    logic                   bang;
    logic                   inject;
    uart_byte_t             inject_data;
    logic                   inject_err;
    logic                   quiet;
    logic                   done;
    logic                   rx_line;
    logic                   tx_line;
    logic                   tx_full;
    uart_byte_t             rd_data;
    logic                   rd_frame_err;
    logic                   rx_empty;
    logic                   rx_overrun;
    int                     pending;
    int                     err_count;
    int                     read_count;
    int                     exp_overruns;
    int                     tper;
    logic [31:0]            lcg_state;

    always #5 clk = ~clk;

    assign rx_line = loop_sel ? tx_line : bang; // loopback mux.

    uart_top i_dut (
        .clk_i          (clk),
        .rst_i          (rst),
        .baud_div_i     (baud_div),
        .stall_i        (stall),
        .wr_en_i        (wr_en),
        .wr_data_i      (wr_data),
        .rd_en_i        (rd_en),
        .rx_i           (rx_line),
        .tx_full_o      (tx_full),
        .tx_o           (tx_line),
        .rd_data_o      (rd_data),
        .rd_frame_err_o (rd_frame_err),
        .rx_empty_o     (rx_empty),
        .rx_overrun_o   (rx_overrun)
    );

    uart_checker u_checker (
        .clk_i          (clk),
        .rst_i          (rst),
        .wr_en_i        (wr_en),
        .wr_data_i      (wr_data),
        .tx_full_i      (tx_full),
        .tx_i           (tx_line),
        .inject_i       (inject),
        .inject_data_i  (inject_data),
        .inject_err_i   (inject_err),
        .quiet_i        (quiet),
        .rd_en_i        (rd_en),
        .rd_data_i      (rd_data),
        .rd_frame_err_i (rd_frame_err),
        .rx_empty_i     (rx_empty),
        .rx_overrun_i   (rx_overrun),
        .done_i         (done),
        .exp_overruns_i (exp_overruns),
        .pending_o      (pending),
        .err_count_o    (err_count),
        .read_count_o   (read_count)
    );

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic uart_byte_t random_byte();
        lcg_state = next_random(lcg_state);
        return lcg_state[23:16]; // the low bits of an LCG repeat too soon.
    endfunction

    function automatic int frames_of(input entry_t e);
        case (e.mode)
            mode_loop:  return 4;
            mode_fill:  return DEPTH;
            mode_flood: return DEPTH + 1;
            default:    return 1;
        endcase
    endfunction

    // waits n rising edges, then steps past the edge so drives never race it.
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic write_byte(input uart_byte_t b);
        wr_en   = 1'b1;
        wr_data = b;
        wait_cycles(1);
        wr_en   = 1'b0;
    endtask

    task automatic send_frame(input uart_byte_t b, input logic stop);
        inject      = 1'b1;
        inject_data = b;
        inject_err  = !stop;
        wait_cycles(1);
        inject = 1'b0;
        bang   = 1'b0;
        wait_cycles(tper);
        for (int k = 0; k < `UART_DATA_BITS; k++) begin
            bang = b[k];
            wait_cycles(tper);
        end
        bang = stop;
        wait_cycles(tper);
        bang = 1'b1;
        wait_cycles(tper);
    endtask

    task automatic drain_rx();
        while (pending != 0) begin
            rd_en = !rx_empty;
            wait_cycles(1);
        end
        rd_en = 1'b0;
    endtask

    task automatic run_entry(input entry_t e);
        tper     = int'(e.div) + 1;
        baud_div = e.div;
        loop_sel = (e.mode == mode_loop) || (e.mode == mode_fill);
        case (e.mode)
            mode_loop: begin
                write_byte(e.data);
                repeat (3) write_byte(random_byte());
            end
            mode_inject: begin
                send_frame(e.data, e.stop);
            end
            mode_glitch: begin
                bang = 1'b0; // low for less than half a bit.
                wait_cycles(tper / 2 - 2);
                bang = 1'b1;
                wait_cycles(12 * tper);
            end
            mode_fill: begin
                stall = 1'b1;
                quiet = 1'b1;
                wait_cycles(1);
                repeat (DEPTH + 1) write_byte(random_byte()); // the last one finds the queue full.
                wait_cycles(4 * tper);
                quiet = 1'b0;
                stall = 1'b0;
            end
            default: begin
                repeat (DEPTH + 1) send_frame(random_byte(), 1'b1); // no reads until all are sent.
            end
        endcase
        drain_rx();
        wait_cycles(2 * tper);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence and watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        baud_div     = stim[0].div;
        stall        = 1'b0;
        wr_en        = 1'b0;
        wr_data      = '0;
        rd_en        = 1'b0;
        loop_sel     = 1'b1;
        bang         = 1'b1;
        inject       = 1'b0;
        inject_data  = '0;
        inject_err   = 1'b0;
        quiet        = 1'b0;
        done         = 1'b0;
        tper         = 1;
        lcg_state    = 32'd19887;
        exp_overruns = 0;
        for (int i = 0; i < NUM; i++) begin
            if (stim[i].mode == mode_flood) exp_overruns++;
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        wait_cycles(2);
        for (int i = 0; i < NUM; i++) begin
            run_entry(stim[i]);
        end
        done = 1'b1;
        wait_cycles(2);
        $display("closing: %0d errors, %0d reads checked", err_count, read_count);
        if (err_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        int limit;
        limit = 2000;
        @(negedge rst);
        for (int i = 0; i < NUM; i++) begin
            limit += (frames_of(stim[i]) * 12 + 8) * (int'(stim[i].div) + 1);
        end
        repeat (limit) @(posedge clk);
        $display("timeout: the stimulus table did not finish within %0d cycles", limit);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: test/uart_checker.sv
// Scoreboard for the UART; it assumes frames reach rx_i in the order they were written or injected.
`timescale 1ns/1ps

`include "uart_params.svh"

module uart_checker (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 wr_en_i,
    input  uart_pkg::uart_byte_t wr_data_i,
    input  logic                 tx_full_i,
    input  logic                 tx_i,
    input  logic                 inject_i,
    input  uart_pkg::uart_byte_t inject_data_i,
    input  logic                 inject_err_i,
    input  logic                 quiet_i,
    input  logic                 rd_en_i,
    input  uart_pkg::uart_byte_t rd_data_i,
    input  logic                 rd_frame_err_i,
    input  logic                 rx_empty_i,
    input  logic                 rx_overrun_i,
    input  logic                 done_i,
    input  int                   exp_overruns_i,
    output int                   pending_o,
    output int                   err_count_o,
    output int                   read_count_o
);

    import uart_pkg::*;

    localparam int DEPTH = `UART_FIFO_DEPTH;

    uart_rx_word_t exp_q [$];
    uart_rx_word_t word;
    int            fill_cnt;
    int            overruns;
    logic          rst_q;
    logic          stray_seen;
    logic          done_seen;

    task automatic report_value(input string name, input logic [31:0] exp_v,
                                input logic [31:0] got_v);
        $display("[ERROR] %0t ns: %s expected %0h got %0h", $time, name, exp_v, got_v);
        err_count_o++;
    endtask

    task automatic report_text(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        err_count_o++;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // model of both queues, sampled on the rising edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk_i) begin
        if (rst_i) begin
            exp_q.delete();
            fill_cnt     = 0;
            overruns     = 0;
            err_count_o  = 0;
            read_count_o = 0;
            stray_seen   = 1'b0;
            done_seen    = 1'b0;
        end else begin
            if (rst_q) begin
                if (tx_i !== 1'b1) report_value("tx_o", 1, tx_i); // state right after reset.
                if (tx_full_i !== 1'b0) report_value("tx_full_o", 0, tx_full_i);
                if (rx_empty_i !== 1'b1) report_value("rx_empty_o", 1, rx_empty_i);
                if (rx_overrun_i !== 1'b0) report_value("rx_overrun_o", 0, rx_overrun_i);
            end
            if (wr_en_i && !tx_full_i) begin
                word.frame_err = 1'b0; // an accepted write comes back over the loopback.
                word.data      = wr_data_i;
                exp_q.push_back(word);
            end
            if (inject_i) begin
                word.frame_err = inject_err_i;
                word.data      = inject_data_i;
                exp_q.push_back(word);
            end
            // with the line held, nothing drains the transmit queue.
            if (quiet_i) begin
                if (tx_i !== 1'b1) report_value("tx_o", 1, tx_i);
                if (tx_full_i !== (fill_cnt == DEPTH)) begin
                    report_value("tx_full_o", fill_cnt == DEPTH, tx_full_i);
                end
                if (wr_en_i && fill_cnt < DEPTH) fill_cnt++;
            end else begin
                fill_cnt = 0;
            end
            if (rx_overrun_i) begin
                if (exp_q.size() > DEPTH) begin
                    exp_q.delete(DEPTH); // the full queue holds the DEPTH older frames.
                    overruns++;
                end else begin
                    report_text("rx_overrun_o pulsed while the receive queue had room");
                end
            end
            if (rx_empty_i) begin
                stray_seen = 1'b0;
            end else if (exp_q.size() == 0 && !stray_seen) begin
                report_text("a word reached the receive queue that nobody sent");
                stray_seen = 1'b1;
            end
            if (rd_en_i && !rx_empty_i && exp_q.size() != 0) begin
                word = exp_q.pop_front();
                read_count_o++;
                if (rd_data_i !== word.data) report_value("rd_data_o", word.data, rd_data_i);
                if (rd_frame_err_i !== word.frame_err) begin
                    report_value("rd_frame_err_o", word.frame_err, rd_frame_err_i);
                end
            end
            if (done_i && !done_seen) begin
                done_seen = 1'b1;
                if (exp_q.size() != 0) begin
                    report_text($sformatf("%0d words never reached the read port", exp_q.size()));
                end
                if (overruns != exp_overruns_i) begin
                    report_value("rx_overrun_o pulses", exp_overruns_i, overruns);
                end
            end
        end
        pending_o = exp_q.size();
        rst_q     = rst_i;
    end

endmodule

// File: design/uart_top.sv
// UART with transmit and receive queues; tx_o and rx_i are not joined here, writes while tx_full_o is high are lost.
`timescale 1ns/1ps

`include "uart_params.svh"

module uart_top (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic [`UART_DIV_W-1:0] baud_div_i,
    input  logic                   stall_i,
    input  logic                   wr_en_i,
    input  uart_pkg::uart_byte_t   wr_data_i,
    input  logic                   rd_en_i,
    input  logic                   rx_i,
    output logic                   tx_full_o,
    output logic                   tx_o,
    output uart_pkg::uart_byte_t   rd_data_o,
    output logic                   rd_frame_err_o,
    output logic                   rx_empty_o,
    output logic                   rx_overrun_o
);

    import uart_pkg::*;

    uart_byte_t    tx_head;
    logic          tx_empty;
    logic          tx_pop;
    uart_rx_word_t rx_word;
    uart_rx_word_t rx_head;
    logic          rx_push;
    logic          rx_full;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // transmit path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    uart_fifo #(
        .DEPTH (`UART_FIFO_DEPTH),
        .T     (uart_byte_t)
    ) u_tx_fifo (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .push_i      (wr_en_i),
        .push_data_i (wr_data_i),
        .pop_i       (tx_pop),
        .head_o      (tx_head),
        .full_o      (tx_full_o),
        .empty_o     (tx_empty)
    );

    uart_tx_serializer u_tx_ser (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .baud_div_i   (baud_div_i),
        .stall_i      (stall_i),
        .fifo_empty_i (tx_empty),
        .fifo_head_i  (tx_head),
        .fifo_pop_o   (tx_pop),
        .tx_o         (tx_o)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // receive path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    uart_rx_deserializer u_rx_deser (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .baud_div_i  (baud_div_i),
        .rx_i        (rx_i),
        .fifo_full_i (rx_full),
        .fifo_push_o (rx_push),
        .fifo_word_o (rx_word),
        .overrun_o   (rx_overrun_o)
    );

    uart_fifo #(
        .DEPTH (`UART_FIFO_DEPTH),
        .T     (uart_rx_word_t)
    ) u_rx_fifo (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .push_i      (rx_push),
        .push_data_i (rx_word),
        .pop_i       (rd_en_i),
        .head_o      (rx_head),
        .full_o      (rx_full),
        .empty_o     (rx_empty_o)
    );

    assign rd_data_o      = rx_head.data;
    assign rd_frame_err_o = rx_head.frame_err;

endmodule

// File: design/uart_rx_deserializer.sv
// Receives 8N1 frames without oversampling; one sample per bit at mid-period, a word is lost when the queue is full.
`timescale 1ns/1ps

`include "uart_params.svh"

module uart_rx_deserializer (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic [`UART_DIV_W-1:0]  baud_div_i,
    input  logic                    rx_i,
    input  logic                    fifo_full_i,
    output logic                    fifo_push_o,
    output uart_pkg::uart_rx_word_t fifo_word_o,
    output logic                    overrun_o
);

    import uart_pkg::*;

    localparam int IW = $clog2(`UART_DATA_BITS);
    localparam logic [IW-1:0] last_idx = IW'(`UART_DATA_BITS - 1);

    typedef enum logic [1:0] {
        s_idle,
        s_start,
        s_data,
        s_stop
    } state_t;

    state_t                 state_q;
    logic                   rx_meta;
    logic                   rx_sync;
    logic                   rx_prev;
    logic                   fall;
    logic [`UART_DIV_W-1:0] bit_cnt;
    logic                   half_hit;
    logic                   full_hit;
    logic [IW-1:0]          bit_idx;
    uart_byte_t             shift_q;
    logic                   stop_done;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // line synchronizer and edge detect
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rx_meta <= 1'b1; // the idle line is high.
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign fall     = rx_prev && !rx_sync;
    assign half_hit = (bit_cnt >= (baud_div_i >> 1));
    assign full_hit = (bit_cnt >= baud_div_i);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // frame FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= s_idle;
            bit_cnt <= '0;
            bit_idx <= '0;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
            case (state_q)
                s_idle: begin
                    bit_cnt <= '0;
                    if (fall) begin
                        state_q <= s_start; // counts to the middle of the start bit.
                    end
                end
                s_start: begin
                    if (half_hit) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        state_q <= rx_sync ? s_idle : s_data; // high here means a glitch.
                    end
                end
                s_data: begin
                    if (full_hit) begin
                        bit_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == last_idx) begin
                            state_q <= s_stop;
                        end
                    end
                end
                default: begin
                    if (full_hit) begin
                        state_q <= s_idle;
                    end
                end
            endcase
        end
    end

    // bits arrive LSB first, so each one enters at the top and moves down.
    always_ff @(posedge clk_i) begin
        if (state_q == s_data && full_hit) begin
            shift_q <= {rx_sync, shift_q[`UART_DATA_BITS-1:1]};
        end
    end

    assign stop_done = (state_q == s_stop) && full_hit;

    assign fifo_word_o.frame_err = !rx_sync; // the stop sample must be high.
    assign fifo_word_o.data      = shift_q;
    assign fifo_push_o           = stop_done && !fifo_full_i;
    assign overrun_o             = stop_done && fifo_full_i;

endmodule

// File: design/uart_tx_serializer.sv
// Sends 8N1 frames from the queue head; stall_i is seen only between frames, the byte retires after its stop bit.
`timescale 1ns/1ps

`include "uart_params.svh"

module uart_tx_serializer (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic [`UART_DIV_W-1:0] baud_div_i,
    input  logic                   stall_i,
    input  logic                   fifo_empty_i,
    input  uart_pkg::uart_byte_t   fifo_head_i,
    output logic                   fifo_pop_o,
    output logic                   tx_o
);

    localparam int IW = $clog2(`UART_DATA_BITS);
    localparam logic [IW-1:0] last_idx = IW'(`UART_DATA_BITS - 1);

    typedef enum logic [1:0] {
        s_idle,
        s_start,
        s_data,
        s_stop
    } state_t;

    state_t                 state_q;
    logic [IW-1:0]          bit_idx;
    logic [`UART_DIV_W-1:0] bit_cnt;
    logic                   bit_tick;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bit timing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the compare is >= so a divisor lowered mid-count still wraps.
    assign bit_tick = (bit_cnt >= baud_div_i);

    always_ff @(posedge clk_i) begin
        if (rst_i || bit_tick) begin
            bit_cnt <= '0;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // frame FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign fifo_pop_o = (state_q == s_stop) && bit_tick; // the byte leaves as the line goes idle.

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= s_idle;
            bit_idx <= '0;
            tx_o    <= 1'b1;
        end else if (bit_tick) begin
            case (state_q)
                s_idle: begin
                    if (!fifo_empty_i && !stall_i) begin
                        state_q <= s_start;
                        tx_o    <= 1'b0;
                    end
                end
                s_start: begin
                    state_q <= s_data;
                    bit_idx <= '0;
                    tx_o    <= fifo_head_i[0];
                end
                s_data: begin
                    if (bit_idx == last_idx) begin
                        state_q <= s_stop;
                        tx_o    <= 1'b1;
                    end else begin
                        bit_idx <= bit_idx + 1'b1;
                        tx_o    <= fifo_head_i[bit_idx + 1'b1];
                    end
                end
                default: begin
                    state_q <= s_idle; // end of the stop bit.
                    tx_o    <= 1'b1;
                end
            endcase
        end
    end

    a_pop_ends_frame: assert property (@(posedge clk_i) disable iff (rst_i)
        fifo_pop_o |-> !fifo_empty_i ##1 (state_q == s_idle));

    a_idle_high: assert property (@(posedge clk_i) disable iff (rst_i)
        (state_q == s_idle) |-> tx_o);

endmodule

// File: design/uart_fifo.sv
// Synchronous FIFO with no bypass; a push when full and a pop when empty are dropped.
`timescale 1ns/1ps

`include "uart_params.svh"

module uart_fifo #(
    parameter int  DEPTH = `UART_FIFO_DEPTH,
    parameter type T     = uart_pkg::uart_byte_t
) (
    input  logic clk_i,
    input  logic rst_i,
    input  logic push_i,
    input  T     push_data_i,
    input  logic pop_i,
    output T     head_o,
    output logic full_o,
    output logic empty_o
);

    localparam int AW = $clog2(DEPTH);

    T            mem [DEPTH];
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        do_push;
    logic        do_pop;

    // the extra top bit tells a full buffer from an empty one.
    assign empty_o = (wr_ptr == rd_ptr);
    assign full_o  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    assign head_o = mem[rd_ptr[AW-1:0]]; // head is valid whenever empty_o is low.

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= push_data_i;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_occupancy: assert property (@(posedge clk_i) disable iff (rst_i)
        (AW + 1)'(wr_ptr - rd_ptr) <= DEPTH);

endmodule

// File: design/uart_pkg.sv
// Payload types shared by the queues and serial stages; the widths come from uart_params.svh.
`include "uart_params.svh"

package uart_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // payload types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one data byte as it sits in the transmit queue.
    typedef logic [`UART_DATA_BITS-1:0] uart_byte_t;

    // one received frame as it sits in the receive queue.
    typedef struct packed {
        logic       frame_err; // set when the stop bit was sampled low.
        uart_byte_t data;
    } uart_rx_word_t;

    // 9 bits in all, the flag sits above the byte.
    localparam int RX_WORD_W = $bits(uart_rx_word_t);

endpackage

// File: design/uart_params.svh
// Build-time sizes for the UART; UART_FIFO_DEPTH must be a power of two of at least 2.
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame and queue sizes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// data bits per frame, sent LSB first.
`define UART_DATA_BITS 8

// width of the run-time divisor, one bit lasts divisor + 1 clocks.
`define UART_DIV_W 16

// entries in each of the transmit and receive queues.
`define UART_FIFO_DEPTH 16

`endif
